//--- source/uart_cfg_pkg.sv
// UART frame settings with word types and the data length decode
`default_nettype none

package uart_cfg_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int DATA_W = 9;                  // Sized for the longest frame

    typedef logic [DATA_W-1:0] data_t;          // Data word, LSB sent first
    typedef logic [2:0]        len_code_t;      // Data length code from the host
    typedef logic [3:0]        bit_len_t;       // Decoded number of data bits

    // Unknown length codes fall back to 8 bits
    localparam bit_len_t DEFAULT_LEN = 4'd8;

    // ----------------------------------------
    // Length decode
    // ----------------------------------------
    // Codes 0 to 4 give 5 to 9 bits
    function automatic bit_len_t decode_len(input len_code_t code);
        bit_len_t len;
        case (code)
            3'd0:    len = 4'd5;
            3'd1:    len = 4'd6;
            3'd2:    len = 4'd7;
            3'd3:    len = 4'd8;
            3'd4:    len = 4'd9;
            default: len = DEFAULT_LEN;
        endcase
        return len;
    endfunction

endpackage

`default_nettype wire

//--- source/uart_fsm_pkg.sv
// State encodings and counter types for the UART bit-level machines
`default_nettype none

package uart_fsm_pkg;

    // Transmit shifter states
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    // Receive deframer states
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    typedef logic [3:0] bit_idx_t;      // Data bit position in the frame
    typedef logic       stop_cnt_t;     // At most two stop bits

endpackage

`default_nettype wire

//--- source/uart_frame_if.sv
// Prepared frame handoff between the TX framer and the TX shifter
`timescale 1ns/1ps
`default_nettype none

interface uart_frame_if;

    logic                   valid;          // Frame buffer holds a word
    logic                   ready;          // Shifter is idle
    uart_cfg_pkg::data_t    data;           // Unused high bits already cleared
    uart_cfg_pkg::bit_len_t len;
    logic                   parity_en;
    logic                   parity_bit;     // Line level of the parity bit
    logic                   two_stop;

    modport framer
    (
        output valid, data, len, parity_en, parity_bit, two_stop,
        input  ready
    );

    modport shifter
    (
        input  valid, data, len, parity_en, parity_bit, two_stop,
        output ready
    );

endinterface

`default_nettype wire

//--- source/uart_tx_framer.sv
// UART transmit framer with host handshake, frame buffer and parity generation
`timescale 1ns/1ps
`default_nettype none

module uart_tx_framer
(
    input  wire logic                    uart_clk,
    input  wire logic                    reset,
    input  wire logic                    tx_req,
    input  wire uart_cfg_pkg::data_t     tx_data,
    input  wire uart_cfg_pkg::len_code_t data_bits,
    input  wire logic                    parity_en,
    input  wire logic                    parity_even,
    input  wire logic                    two_stop,
    output logic                         tx_ack,
    uart_frame_if.framer                 frame
);

    uart_cfg_pkg::bit_len_t len;
    uart_cfg_pkg::data_t    mask;
    uart_cfg_pkg::data_t    data_masked;
    logic                   load;

    assign len         = uart_cfg_pkg::decode_len(data_bits);
    assign mask        = (uart_cfg_pkg::data_t'(1) << len) - uart_cfg_pkg::data_t'(1);
    assign data_masked = tx_data & mask;

    // Buffer empty, or emptied by a transfer in this cycle
    assign load = tx_req && !tx_ack && (!frame.valid || frame.ready);

    // ----------------------------------------
    // Handshake and buffer state
    // ----------------------------------------
    always_ff @(posedge uart_clk)
    begin
        if (reset)
        begin
            tx_ack      <= 1'b0;
            frame.valid <= 1'b0;
        end
        else
        begin
            if (load)
                tx_ack <= 1'b1;
            else if (!tx_req)
                tx_ack <= 1'b0;             // Host has released the request

            if (load)
                frame.valid <= 1'b1;
            else if (frame.ready)
                frame.valid <= 1'b0;        // Word taken by the shifter
        end
    end

    // Frame fields, captured once per word
    always_ff @(posedge uart_clk)
    begin
        if (load)
        begin
            frame.data       <= data_masked;
            frame.len        <= len;
            frame.parity_en  <= parity_en;
            frame.parity_bit <= parity_even ? ^data_masked : ~^data_masked;
            frame.two_stop   <= two_stop;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_tx_shifter.sv
// UART transmit shifter that times and serializes one frame onto the line
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shifter
#(
    parameter int clks_per_bit = 16
)
(
    input  wire logic     uart_clk,
    input  wire logic     reset,
    uart_frame_if.shifter frame,
    output logic          tx
);

    localparam int               CNT_W   = $clog2(clks_per_bit);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(clks_per_bit - 1);

    uart_fsm_pkg::tx_state_t state;
    logic [CNT_W-1:0]        bit_cnt;
    uart_fsm_pkg::bit_idx_t  bit_idx;
    uart_fsm_pkg::bit_idx_t  last_idx;
    uart_fsm_pkg::stop_cnt_t stop_cnt;
    uart_cfg_pkg::data_t     shreg;         // Remaining data bits, LSB next
    uart_cfg_pkg::bit_len_t  len;
    logic                    parity_en;
    logic                    parity_bit;
    logic                    two_stop;
    logic                    bit_end;

    assign frame.ready = (state == uart_fsm_pkg::TX_IDLE);
    assign bit_end     = (bit_cnt == BIT_END);
    assign last_idx    = uart_fsm_pkg::bit_idx_t'(len - 4'd1);

    always_ff @(posedge uart_clk)
    begin
        if (reset)
        begin
            state    <= uart_fsm_pkg::TX_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            stop_cnt <= '0;
            tx       <= 1'b1;               // Line idles high
        end
        else
        begin
            // Bit timer runs in every state but idle
            if (state == uart_fsm_pkg::TX_IDLE || bit_end)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;

            case (state)
                uart_fsm_pkg::TX_IDLE:
                begin
                    if (frame.valid)
                    begin
                        shreg      <= frame.data;
                        len        <= frame.len;
                        parity_en  <= frame.parity_en;
                        parity_bit <= frame.parity_bit;
                        two_stop   <= frame.two_stop;
                        bit_idx    <= '0;
                        stop_cnt   <= '0;
                        tx         <= 1'b0;     // Start bit
                        state      <= uart_fsm_pkg::TX_START;
                    end
                end
                uart_fsm_pkg::TX_START:
                begin
                    if (bit_end)
                    begin
                        tx    <= shreg[0];
                        shreg <= shreg >> 1;
                        state <= uart_fsm_pkg::TX_DATA;
                    end
                end
                uart_fsm_pkg::TX_DATA:
                begin
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == last_idx)
                        begin
                            tx    <= parity_en ? parity_bit : 1'b1;
                            state <= parity_en ? uart_fsm_pkg::TX_PARITY : uart_fsm_pkg::TX_STOP;
                        end
                        else
                        begin
                            tx    <= shreg[0];
                            shreg <= shreg >> 1;
                        end
                    end
                end
                uart_fsm_pkg::TX_PARITY:
                begin
                    if (bit_end)
                    begin
                        tx    <= 1'b1;
                        state <= uart_fsm_pkg::TX_STOP;
                    end
                end
                uart_fsm_pkg::TX_STOP:
                begin
                    if (bit_end)
                    begin
                        if (stop_cnt == uart_fsm_pkg::stop_cnt_t'(two_stop))
                            state <= uart_fsm_pkg::TX_IDLE;
                        else
                            stop_cnt <= stop_cnt + 1'b1;
                    end
                end
                default:
                begin
                    tx    <= 1'b1;
                    state <= uart_fsm_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/uart_rx_deframer.sv
// UART receive deframer with start detection, mid-bit sampling and parity check
`timescale 1ns/1ps
`default_nettype none

module uart_rx_deframer
#(
    parameter int clks_per_bit = 16
)
(
    input  wire logic                    uart_clk,
    input  wire logic                    reset,
    input  wire logic                    rx,
    input  wire uart_cfg_pkg::len_code_t data_bits,
    input  wire logic                    parity_en,
    input  wire logic                    parity_even,
    input  wire logic                    two_stop,
    output uart_cfg_pkg::data_t          rx_data,
    output logic                         rx_valid,
    output logic                         rx_parity_error
);

    localparam int               CNT_W    = $clog2(clks_per_bit);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(clks_per_bit - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(clks_per_bit / 2 - 1);

    uart_fsm_pkg::rx_state_t state;
    logic [CNT_W-1:0]        bit_cnt;
    uart_fsm_pkg::bit_idx_t  bit_idx;
    uart_fsm_pkg::bit_idx_t  last_idx;
    uart_fsm_pkg::stop_cnt_t stop_cnt;
    uart_cfg_pkg::bit_len_t  len;
    uart_cfg_pkg::data_t     word;          // Word being assembled
    logic                    rx_q;
    logic                    par_acc;       // Running XOR of data bits
    logic                    par_err;
    logic                    bit_end;

    assign len      = uart_cfg_pkg::decode_len(data_bits);
    assign last_idx = uart_fsm_pkg::bit_idx_t'(len - 4'd1);

    // Half a bit for the start check, a full bit after that
    assign bit_end = (state == uart_fsm_pkg::RX_START) ? (bit_cnt == HALF_END)
                                                       : (bit_cnt == BIT_END);

    always_ff @(posedge uart_clk)
    begin
        if (reset)
        begin
            rx_q            <= 1'b1;
            state           <= uart_fsm_pkg::RX_IDLE;
            bit_cnt         <= '0;
            bit_idx         <= '0;
            stop_cnt        <= '0;
            rx_valid        <= 1'b0;
            rx_parity_error <= 1'b0;
        end
        else
        begin
            rx_q     <= rx;
            rx_valid <= 1'b0;

            if (state == uart_fsm_pkg::RX_IDLE || bit_end)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;

            case (state)
                uart_fsm_pkg::RX_IDLE:
                begin
                    if (!rx_q)
                        state <= uart_fsm_pkg::RX_START;    // Possible start edge
                end
                uart_fsm_pkg::RX_START:
                begin
                    if (bit_end)
                    begin
                        bit_idx  <= '0;
                        stop_cnt <= '0;
                        word     <= '0;
                        par_acc  <= 1'b0;
                        par_err  <= 1'b0;
                        // High at mid-bit means a glitch
                        state    <= rx_q ? uart_fsm_pkg::RX_IDLE : uart_fsm_pkg::RX_DATA;
                    end
                end

                // ----------------------------------------
                // Data and parity sampling
                // ----------------------------------------
                uart_fsm_pkg::RX_DATA:
                begin
                    if (bit_end)
                    begin
                        word[bit_idx] <= rx_q;
                        par_acc       <= par_acc ^ rx_q;
                        bit_idx       <= bit_idx + 1'b1;
                        if (bit_idx == last_idx)
                            state <= parity_en ? uart_fsm_pkg::RX_PARITY : uart_fsm_pkg::RX_STOP;
                    end
                end
                uart_fsm_pkg::RX_PARITY:
                begin
                    if (bit_end)
                    begin
                        // Odd parity expects the inverted XOR
                        par_err <= par_acc ^ rx_q ^ ~parity_even;
                        state   <= uart_fsm_pkg::RX_STOP;
                    end
                end
                uart_fsm_pkg::RX_STOP:
                begin
                    if (bit_end)
                    begin
                        if (stop_cnt == uart_fsm_pkg::stop_cnt_t'(two_stop))
                        begin
                            rx_valid        <= 1'b1;
                            rx_data         <= word;
                            rx_parity_error <= par_err & parity_en;
                            state           <= uart_fsm_pkg::RX_IDLE;
                        end
                        else
                        begin
                            stop_cnt <= stop_cnt + 1'b1;
                        end
                    end
                end
                default:
                    state <= uart_fsm_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/uart_device.sv
// UART device top level joining the transmit pipeline and the receiver
`timescale 1ns/1ps
`default_nettype none

module uart_device
#(
    parameter int clks_per_bit = 16         // uart_clk cycles per bit, 4 or more
)
(
    input  wire logic                    uart_clk,
    input  wire logic                    reset,

    // Host side of the transmitter
    input  wire logic                    tx_req,
    output logic                         tx_ack,
    input  wire uart_cfg_pkg::data_t     tx_data,

    // Frame settings shared by both directions
    input  wire uart_cfg_pkg::len_code_t data_bits,
    input  wire logic                    parity_en,
    input  wire logic                    parity_even,
    input  wire logic                    two_stop,

    // Serial lines
    output logic                         tx,
    input  wire logic                    rx,

    // Received word
    output uart_cfg_pkg::data_t          rx_data,
    output logic                         rx_valid,
    output logic                         rx_parity_error
);

    // ----------------------------------------
    // Transmit pipeline
    // ----------------------------------------
    uart_frame_if frame_i ();

    uart_tx_framer framer_i
    (
        .uart_clk    (uart_clk),
        .reset       (reset),
        .tx_req      (tx_req),
        .tx_data     (tx_data),
        .data_bits   (data_bits),
        .parity_en   (parity_en),
        .parity_even (parity_even),
        .two_stop    (two_stop),
        .tx_ack      (tx_ack),
        .frame       (frame_i.framer)
    );

    uart_tx_shifter #(.clks_per_bit(clks_per_bit)) shifter_i
    (
        .uart_clk (uart_clk),
        .reset    (reset),
        .frame    (frame_i.shifter),
        .tx       (tx)
    );

    // ----------------------------------------
    // Receiver
    // ----------------------------------------
    uart_rx_deframer #(.clks_per_bit(clks_per_bit)) deframer_i
    (
        .uart_clk        (uart_clk),
        .reset           (reset),
        .rx              (rx),
        .data_bits       (data_bits),
        .parity_en       (parity_en),
        .parity_even     (parity_even),
        .two_stop        (two_stop),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_parity_error (rx_parity_error)
    );

endmodule

`default_nettype wire

//--- sim/tb_uart_device.sv
// Loopback testbench for the UART device, driven from a table of frames
`timescale 1ns/1ps
`default_nettype none

module tb_uart_device;

    localparam int         CLK_PERIOD   = 4;
    localparam int         CLKS_PER_BIT = 16;
    localparam int         NUM_ENTRIES  = 22;
    localparam logic [3:0] NO_CORRUPT   = 4'hF;
    localparam int         WATCHDOG_NS  = NUM_ENTRIES * 13 * CLKS_PER_BIT * CLK_PERIOD * 2 + 2000;

    typedef struct packed
    {
        uart_cfg_pkg::data_t     data;
        uart_cfg_pkg::len_code_t code;
        logic                    parity_en;
        logic                    parity_even;
        logic                    two_stop;
        logic [3:0]              corrupt;       // Data bit inverted on the line
        logic                    chain;         // Request as soon as the last ack drops
    } entry_t;

    logic                    uart_clk;
    logic                    reset;
    logic                    tx_req;
    uart_cfg_pkg::data_t     tx_data;
    uart_cfg_pkg::len_code_t data_bits;
    logic                    parity_en;
    logic                    parity_even;
    logic                    two_stop;
    logic                    tx;
    logic                    rx;
    logic                    tx_ack;
    uart_cfg_pkg::data_t     rx_data;
    logic                    rx_valid;
    logic                    rx_parity_error;
    logic                    flip;

    entry_t              tbl [NUM_ENTRIES];
    int                  n_entries    = 0;
    int                  seed;
    int                  value_errors = 0;
    int                  other_errors = 0;
    int                  checked      = 0;
    int                  sent_count   = 0;
    int                  rcv_count    = 0;
    longint              cycle        = 0;
    longint              last_fall    = 0;  // Cycle of the latest falling edge on tx
    logic                tx_last      = 1'b1;
    uart_cfg_pkg::data_t exp_data_q [$];
    logic                exp_perr_q [$];
    int                  line_q [$];       // Table rows waiting for their start bit
    uart_cfg_pkg::data_t exp_word;
    logic                exp_perr;

    assign rx = tx ^ flip;                  // Loopback with optional bit inversion

    uart_device #(.clks_per_bit(CLKS_PER_BIT)) dut_i
    (
        .uart_clk        (uart_clk),
        .reset           (reset),
        .tx_req          (tx_req),
        .tx_ack          (tx_ack),
        .tx_data         (tx_data),
        .data_bits       (data_bits),
        .parity_en       (parity_en),
        .parity_even     (parity_even),
        .two_stop        (two_stop),
        .tx              (tx),
        .rx              (rx),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_parity_error (rx_parity_error)
    );

    initial uart_clk = 1'b0;
    always #(CLK_PERIOD / 2) uart_clk = ~uart_clk;

    always @(posedge uart_clk) cycle <= cycle + 1;

    // Falling edges of the tx line
    always @(posedge uart_clk)
    begin
        tx_last <= tx;
        if (tx_last === 1'b1 && tx === 1'b0)
            last_fall <= cycle;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int data_len(input uart_cfg_pkg::len_code_t code);
        if (code <= 3'd4)
            return 5 + int'(code);
        return 8;                           // Unknown codes
    endfunction

    function automatic int frame_bits(input entry_t e);
        return 1 + data_len(e.code) + int'(e.parity_en) + 1 + int'(e.two_stop);
    endfunction

    function automatic uart_cfg_pkg::data_t expected_word(input entry_t e);
        uart_cfg_pkg::data_t w;
        int                  n;
        n = data_len(e.code);
        w = '0;
        for (int b = 0; b < n; b++)
            w[b] = e.data[b];
        if (e.corrupt != NO_CORRUPT)
            w[e.corrupt] = ~w[e.corrupt];
        return w;
    endfunction

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    task automatic add_entry(input uart_cfg_pkg::data_t data, input uart_cfg_pkg::len_code_t code,
                             input logic pe, input logic pev, input logic two,
                             input logic [3:0] corrupt, input logic chain);
        tbl[n_entries] = {data, code, pe, pev, two, corrupt, chain};
        n_entries++;
    endtask

    task automatic fill_table();
        // Every length code with parity off and one stop bit
        add_entry(uart_cfg_pkg::data_t'($random(seed)), 3'd0, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(9'h0EA, 3'd1, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(uart_cfg_pkg::data_t'($random(seed)), 3'd2, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(9'h1C7, 3'd3, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(uart_cfg_pkg::data_t'($random(seed)), 3'd4, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(9'h1FF, 3'd5, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(uart_cfg_pkg::data_t'($random(seed)), 3'd6, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(9'h16C, 3'd7, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        // Chained pairs of parity types and stop counts with the LSB set
        add_entry(9'h0A5, 3'd3, 1'b1, 1'b1, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(9'h033, 3'd3, 1'b1, 1'b1, 1'b0, NO_CORRUPT, 1'b1);
        add_entry(9'h13B, 3'd4, 1'b1, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(9'h0E1, 3'd4, 1'b1, 1'b0, 1'b0, NO_CORRUPT, 1'b1);
        add_entry(9'h04F, 3'd2, 1'b1, 1'b1, 1'b1, NO_CORRUPT, 1'b0);
        add_entry(9'h07D, 3'd2, 1'b1, 1'b1, 1'b1, NO_CORRUPT, 1'b1);
        add_entry(9'h1F1, 3'd4, 1'b1, 1'b0, 1'b1, NO_CORRUPT, 1'b0);
        add_entry(9'h101, 3'd4, 1'b1, 1'b0, 1'b1, NO_CORRUPT, 1'b1);
        // Corrupted data bits
        add_entry(9'h0F0, 3'd3, 1'b1, 1'b1, 1'b0, 4'd2, 1'b0);
        add_entry(9'h155, 3'd4, 1'b1, 1'b0, 1'b1, 4'd8, 1'b0);
        add_entry(9'h01D, 3'd0, 1'b0, 1'b0, 1'b0, 4'd4, 1'b0);
        add_entry(uart_cfg_pkg::data_t'($random(seed)), 3'd3, 1'b0, 1'b0, 1'b1, 4'd0, 1'b0);
        // Back-to-back pair
        add_entry(9'h05A, 3'd2, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b0);
        add_entry(9'h027, 3'd2, 1'b0, 1'b0, 1'b0, NO_CORRUPT, 1'b1);
    endtask

    task automatic wait_rx_done();
        while (rcv_count != sent_count)
            @(posedge uart_clk);
    endtask

    // Four-phase request for one table row
    task automatic send_entry(input int i);
        entry_t e;
        e = tbl[i];
        data_bits   <= e.code;
        parity_en   <= e.parity_en;
        parity_even <= e.parity_even;
        two_stop    <= e.two_stop;
        tx_data     <= e.data;
        tx_req      <= 1'b1;
        do
            @(posedge uart_clk);
        while (tx_ack !== 1'b1);
        if (e.chain)
        begin
            assert (rcv_count < sent_count)
            else
            begin
                value_errors++;
                $display("[FAIL] %0t: row %0d acknowledged after the previous frame ended",
                         $time, i);
            end
        end
        exp_data_q.push_back(expected_word(e));
        exp_perr_q.push_back(e.corrupt != NO_CORRUPT ? e.parity_en : 1'b0);
        line_q.push_back(i);
        sent_count++;
        tx_req <= 1'b0;
        do
            @(posedge uart_clk);
        while (tx_ack !== 1'b0);
    endtask

    // ----------------------------------------
    // Line monitor and corruption
    // ----------------------------------------
    initial
    begin : line_monitor
        entry_t e;
        int     total;
        int     low_run;
        bit     in_run;
        longint start_cyc;
        longint prev_start;
        int     prev_bits;
        prev_start = 0;
        prev_bits  = 0;
        forever
        begin
            @(posedge uart_clk);
            if (!reset && tx === 1'b0)
            begin
                if (line_q.size() == 0)
                begin
                    other_errors++;
                    $display("The tx line went low at %0t with no word pending", $time);
                    while (tx === 1'b0)
                        @(posedge uart_clk);
                end
                else
                begin
                    e         = tbl[line_q.pop_front()];
                    total     = frame_bits(e) * CLKS_PER_BIT;
                    start_cyc = (tx_last === 1'b1) ? cycle : last_fall;  // Edge that began the low
                    if (e.chain)
                    begin
                        assert (start_cyc - prev_start >= prev_bits * CLKS_PER_BIT)
                        else
                        begin
                            value_errors++;
                            $display("[FAIL] %0t: frame spacing %0d cycles, expected %0d or more",
                                     $time, start_cyc - prev_start, prev_bits * CLKS_PER_BIT);
                        end
                    end
                    low_run = 1;
                    in_run  = 1'b1;
                    for (int k = 2; k <= total; k++)
                    begin
                        @(posedge uart_clk);       // Edge k after the falling edge
                        if (in_run && tx === 1'b0)
                            low_run++;
                        else
                            in_run = 1'b0;
                        if (e.corrupt != NO_CORRUPT && k == CLKS_PER_BIT * (1 + e.corrupt))
                            flip <= 1'b1;
                        else if (e.corrupt != NO_CORRUPT && k == CLKS_PER_BIT * (2 + e.corrupt))
                            flip <= 1'b0;
                    end
                    assert (e.data[0] ? low_run == CLKS_PER_BIT : low_run >= CLKS_PER_BIT)
                    else
                    begin
                        value_errors++;
                        $display("[FAIL] %0t: start bit low for %0d cycles", $time, low_run);
                    end
                    prev_start = start_cyc;
                    prev_bits  = frame_bits(e);
                end
            end
        end
    end

    // Received words against the expected queue
    always @(posedge uart_clk)
    begin
        if (!reset && rx_valid === 1'b1)
        begin
            if (exp_data_q.size() == 0)
            begin
                other_errors++;
                $display("A word was received at %0t when none was expected", $time);
            end
            else
            begin
                exp_word = exp_data_q.pop_front();
                exp_perr = exp_perr_q.pop_front();
                checked++;
                assert (rx_data === exp_word)
                else
                begin
                    value_errors++;
                    $display("[FAIL] %0t: rx_data %h, expected %h", $time, rx_data, exp_word);
                end
                assert (rx_parity_error === exp_perr)
                else
                begin
                    value_errors++;
                    $display("[FAIL] %0t: rx_parity_error %b, expected %b",
                             $time, rx_parity_error, exp_perr);
                end
            end
            rcv_count <= rcv_count + 1;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin : main
        seed = 74;
        reset       <= 1'b1;
        tx_req      <= 1'b0;
        tx_data     <= '0;
        data_bits   <= 3'd3;
        parity_en   <= 1'b0;
        parity_even <= 1'b0;
        two_stop    <= 1'b0;
        flip        <= 1'b0;
        fill_table();
        repeat (2) @(posedge uart_clk);
        reset <= 1'b0;
        @(posedge uart_clk);
        assert (tx === 1'b1 && tx_ack === 1'b0 && rx_valid === 1'b0)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t: after reset tx=%b tx_ack=%b rx_valid=%b",
                     $time, tx, tx_ack, rx_valid);
        end

        for (int i = 0; i < n_entries; i++)
        begin
            if (!tbl[i].chain)
                wait_rx_done();             // Settings change only on a quiet receiver
            send_entry(i);
        end
        wait_rx_done();
        repeat (2 * CLKS_PER_BIT) @(posedge uart_clk);

        if (exp_data_q.size() != 0)
        begin
            other_errors++;
            $display("%0d expected words never arrived", exp_data_q.size());
        end
        $display("Summary: %0d words checked, %0d value errors, %0d other errors",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_device.f
source/uart_cfg_pkg.sv
source/uart_fsm_pkg.sv
source/uart_frame_if.sv
source/uart_tx_framer.sv
source/uart_tx_shifter.sv
source/uart_rx_deframer.sv
source/uart_device.sv
sim/tb_uart_device.sv

//--- run_sim.sh
#!/bin/sh
# Builds the UART device testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_uart_device \
    -f uart_device.f \
    -o tb_uart_device

./obj_dir/tb_uart_device | tee "$LOG"

if grep -q "TEST PASSED" "$LOG"; then
    echo "Simulation log reports success"
else
    echo "Simulation log reports failure"
    exit 1
fi
